// File: logic/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // ------------------------------------------------------------
    // Address and beat geometry
    // ------------------------------------------------------------
    localparam int ADDR_W     = 32;

    // One beat is 8 bytes
    localparam int BEAT_SHIFT = 3;

    typedef logic [ADDR_W-1:0] mem_addr_t;

    // ------------------------------------------------------------
    // Read request types
    // ------------------------------------------------------------
    typedef enum logic {
        BUF_SETUP = 1'b0,
        BUF_FLUSH = 1'b1
    } buffer_kind_e;

    typedef struct packed {
        mem_addr_t    address;
        buffer_kind_e kind;
    } mem_request_payload_t;

    typedef struct packed {
        logic                 valid;
        mem_request_payload_t payload;
    } mem_request_t;

endpackage : mem_pkg

`default_nettype wire

// File: logic/cu_setup_pkg.sv
`default_nettype none

package cu_setup_pkg;

    import mem_pkg::*;

    // ------------------------------------------------------------
    // Sizing
    // ------------------------------------------------------------
    localparam int COUNT_W     = 16;
    localparam int FIFO_DEPTH  = 16;

    // Engine holds off once this many requests sit in the FIFO
    localparam int PROG_THRESH = 12;

    typedef logic [COUNT_W-1:0] count_t;

    // ------------------------------------------------------------
    // Descriptor and engine configuration
    // ------------------------------------------------------------
    typedef struct packed {
        logic      valid;
        mem_addr_t program_base;
        count_t    program_count;
        logic      flush_enable;
        mem_addr_t flush_base;
        count_t    flush_count;
    } kernel_descriptor_t;

    // One run of beats for the read engine
    typedef struct packed {
        mem_addr_t    base;
        count_t       count;
        buffer_kind_e kind;
    } read_config_t;

    typedef enum logic [2:0] {
        RESET,
        IDLE,
        REQ_START,
        REQ_BUSY,
        REQ_DONE,
        FLUSH_START,
        FLUSH_BUSY,
        FLUSH_DONE
    } cu_setup_state_e;

endpackage : cu_setup_pkg

`default_nettype wire

// File: logic/request_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module request_fifo
    import mem_pkg::*, cu_setup_pkg::*;
#(
    parameter int DEPTH       = FIFO_DEPTH,
    parameter int PROG_THRESH = cu_setup_pkg::PROG_THRESH
) (
    input  wire logic         ap_clk,
    input  wire logic         areset_cu_setup,
    input  wire mem_request_t push,
    input  wire logic         pop_ready,
    output logic              prog_full,
    output mem_request_t      request_out
);

    typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(DEPTH+1)-1:0] level_t;

    mem_request_payload_t mem [DEPTH];
    ptr_t                 wr_ptr;
    ptr_t                 rd_ptr;
    level_t               level;
    logic                 empty;
    logic                 full;
    logic                 do_pop;

    assign empty     = (level == '0);
    assign full      = (level == level_t'(DEPTH));
    assign do_pop    = !empty && pop_ready;
    assign prog_full = (level >= level_t'(PROG_THRESH));

    // ------------------------------------------------------------
    // Storage and pointers
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (push.valid) begin
            mem[wr_ptr] <= push.payload;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (push.valid) begin
                wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + ptr_t'(1);
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + ptr_t'(1);
            end
            case ({push.valid, do_pop})
                2'b10:   level <= level + level_t'(1);
                2'b01:   level <= level - level_t'(1);
                default: level <= level;
            endcase
        end
    end

    // Registered read port valid the cycle after a pop
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            request_out.valid <= 1'b0;
        end else begin
            request_out.valid <= do_pop;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (do_pop) begin
            request_out.payload <= mem[rd_ptr];
        end
    end

    // Threshold must stop the engine before the buffer overflows
    no_push_when_full: assert property (
        @(posedge ap_clk) disable iff (areset_cu_setup)
        push.valid |-> !full
    );

endmodule : request_fifo

`default_nettype wire

// File: logic/serial_read_engine.sv
`timescale 1ns/10ps
`default_nettype none

module serial_read_engine
    import mem_pkg::*, cu_setup_pkg::*;
(
    input  wire logic         ap_clk,
    input  wire logic         areset_cu_setup,
    input  wire logic         start,
    input  wire read_config_t read_cfg,
    input  wire logic         prog_full,
    output mem_request_t      push,
    output logic              idle
);

    read_config_t cfg_q;
    count_t       beat_idx;
    logic         busy;
    logic         issue;
    logic         last_beat;

    // ------------------------------------------------------------
    // Beat stepping
    // ------------------------------------------------------------
    assign issue     = busy && !prog_full && (cfg_q.count != '0);
    assign last_beat = (beat_idx == cfg_q.count - count_t'(1));

    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            busy     <= 1'b0;
            beat_idx <= '0;
        end else if (start) begin
            busy     <= 1'b1;
            beat_idx <= '0;
        end else if (busy) begin
            // Empty run still shows one busy cycle
            if (cfg_q.count == '0) begin
                busy <= 1'b0;
            end else if (issue) begin
                beat_idx <= beat_idx + count_t'(1);
                if (last_beat) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (start) begin
            cfg_q <= read_cfg;
        end
    end

    // ------------------------------------------------------------
    // Request output
    // ------------------------------------------------------------
    assign push.valid           = issue;
    assign push.payload.address = cfg_q.base + (mem_addr_t'(beat_idx) << BEAT_SHIFT);
    assign push.payload.kind    = cfg_q.kind;

    assign idle = !busy;

    // A new run only begins after the previous one has drained
    start_only_when_idle: assert property (
        @(posedge ap_clk) disable iff (areset_cu_setup)
        start |-> !busy
    );

endmodule : serial_read_engine

`default_nettype wire

// File: logic/cu_setup_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module cu_setup_fsm
    import mem_pkg::*, cu_setup_pkg::*;
(
    input  wire logic               ap_clk,
    input  wire logic               areset_cu_setup,
    input  wire kernel_descriptor_t descriptor,
    input  wire logic               cu_flush,
    input  wire logic               response_valid,
    input  wire logic               engine_idle,
    output logic                    start,
    output read_config_t            read_cfg,
    output logic                    done
);

    cu_setup_state_e    state;
    cu_setup_state_e    next_state;
    kernel_descriptor_t desc_q;
    count_t             resp_count;
    logic               flush_phase;
    logic               enter_start;

    // ------------------------------------------------------------
    // Phase state machine
    // ------------------------------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            RESET: begin
                next_state = IDLE;
            end
            IDLE: begin
                if (descriptor.valid) begin
                    next_state = REQ_START;
                end
            end
            // Engine drops idle the cycle after it takes the start
            REQ_START: begin
                if (!engine_idle) begin
                    next_state = REQ_BUSY;
                end
            end
            REQ_BUSY: begin
                if (engine_idle && resp_count == '0) begin
                    next_state = REQ_DONE;
                end
            end
            REQ_DONE: begin
                if (!desc_q.flush_enable) begin
                    next_state = FLUSH_DONE;
                end else if (cu_flush) begin
                    next_state = FLUSH_START;
                end
            end
            FLUSH_START: begin
                if (!engine_idle) begin
                    next_state = FLUSH_BUSY;
                end
            end
            FLUSH_BUSY: begin
                if (engine_idle && resp_count == '0) begin
                    next_state = FLUSH_DONE;
                end
            end
            FLUSH_DONE: begin
                next_state = FLUSH_DONE;
            end
            default: begin
                next_state = RESET;
            end
        endcase
    end

    assign enter_start = (next_state == REQ_START && state != REQ_START) ||
                         (next_state == FLUSH_START && state != FLUSH_START);

    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            state      <= RESET;
            start      <= 1'b0;
            resp_count <= '0;
        end else begin
            state <= next_state;
            start <= enter_start;

            // Response counter loaded as each phase begins
            if (state == IDLE && descriptor.valid) begin
                resp_count <= descriptor.program_count;
            end else if (state == REQ_DONE && next_state == FLUSH_START) begin
                resp_count <= desc_q.flush_count;
            end else if (response_valid) begin
                resp_count <= resp_count - count_t'(1);
            end
        end
    end

    // Descriptor capture
    always_ff @(posedge ap_clk) begin
        if (state == IDLE && descriptor.valid) begin
            desc_q <= descriptor;
        end
    end

    // ------------------------------------------------------------
    // Read configuration for the active phase
    // ------------------------------------------------------------
    assign flush_phase = (state == FLUSH_START) || (state == FLUSH_BUSY);

    always_comb begin
        if (flush_phase) begin
            read_cfg.base  = desc_q.flush_base;
            read_cfg.count = desc_q.flush_count;
            read_cfg.kind  = BUF_FLUSH;
        end else begin
            read_cfg.base  = desc_q.program_base;
            read_cfg.count = desc_q.program_count;
            read_cfg.kind  = BUF_SETUP;
        end
    end

    assign done = (state == FLUSH_DONE);

    // More responses than requested beats
    response_within_count: assert property (
        @(posedge ap_clk) disable iff (areset_cu_setup)
        response_valid |-> resp_count != '0
    );

endmodule : cu_setup_fsm

`default_nettype wire

// File: logic/cu_setup.sv
`timescale 1ns/10ps
`default_nettype none

module cu_setup
    import mem_pkg::*, cu_setup_pkg::*;
(
    input  wire logic               ap_clk,
    input  wire logic               areset_cu_setup,
    input  wire kernel_descriptor_t descriptor_in,
    input  wire logic               cu_flush,
    input  wire logic               response_valid,
    input  wire logic               request_ready,
    output mem_request_t            request_out,
    output logic                    done_out
);

    kernel_descriptor_t descriptor_q;
    logic               cu_flush_q;
    logic               response_valid_q;
    logic               request_ready_q;

    logic               engine_start;
    read_config_t       engine_cfg;
    logic               engine_idle;
    mem_request_t       engine_push;
    logic               fifo_prog_full;
    logic               fsm_done;

    // ------------------------------------------------------------
    // Input registers
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        descriptor_q <= descriptor_in;
        if (areset_cu_setup) begin
            descriptor_q.valid <= 1'b0;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            cu_flush_q       <= 1'b0;
            response_valid_q <= 1'b0;
            request_ready_q  <= 1'b0;
            done_out         <= 1'b0;
        end else begin
            cu_flush_q       <= cu_flush;
            response_valid_q <= response_valid;
            request_ready_q  <= request_ready;
            done_out         <= fsm_done;
        end
    end

    // ------------------------------------------------------------
    // Phase control, read engine and request FIFO
    // ------------------------------------------------------------
    cu_setup_fsm cu_setup_fsm_inst (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup),
        .descriptor      (descriptor_q),
        .cu_flush        (cu_flush_q),
        .response_valid  (response_valid_q),
        .engine_idle     (engine_idle),
        .start           (engine_start),
        .read_cfg        (engine_cfg),
        .done            (fsm_done)
    );

    serial_read_engine serial_read_engine_inst (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup),
        .start           (engine_start),
        .read_cfg        (engine_cfg),
        .prog_full       (fifo_prog_full),
        .push            (engine_push),
        .idle            (engine_idle)
    );

    request_fifo #(
        .DEPTH       (FIFO_DEPTH),
        .PROG_THRESH (PROG_THRESH)
    ) request_fifo_inst (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup),
        .push            (engine_push),
        .pop_ready       (request_ready_q),
        .prog_full       (fifo_prog_full),
        .request_out     (request_out)
    );

endmodule : cu_setup

`default_nettype wire

// File: verif/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Power-on reset released on a rising edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule : tb_clock_gen

`default_nettype wire

// File: verif/cu_setup_tb.sv
`timescale 1ns/10ps
`default_nettype none

module cu_setup_tb
    import mem_pkg::*, cu_setup_pkg::*;
();

    typedef struct packed {
        logic [8*24-1:0] name;
        mem_addr_t       program_base;
        count_t          program_count;
        logic            flush_enable;
        mem_addr_t       flush_base;
        count_t          flush_count;
        int              stall_pct;
        int              flush_delay;
    } test_vector_t;

    logic               clk;
    logic               por_rst;
    logic               test_rst;
    logic               dut_reset;
    kernel_descriptor_t descriptor_in;
    logic               cu_flush;
    logic               response_valid = 1'b0;
    logic               request_ready = 1'b0;
    mem_request_t       request_out;
    logic               done_out;

    test_vector_t tests[$];
    test_vector_t cur;
    string        cur_name;
    bit           monitor_on;
    bit           tests_loaded;
    int           watchdog_cycles;

    // Memory model state owned by the negedge process
    int  seed = 32'h6bd9_4df3;
    int  cycle;
    int  release_q[$];
    int  prog_seen;
    int  flush_seen;
    int  resp_sent;
    bit  done_seen;
    bit  ready_next = 1'b1;
    bit  resp_next;
    // request_ready as sampled one and two cycles back
    bit  ready_d1;
    bit  ready_d2;

    assign dut_reset = por_rst | test_rst;

    tb_clock_gen #(
        .PERIOD_NS    (10),
        .RESET_CYCLES (5)
    ) tb_clock_gen_inst (
        .clk (clk),
        .rst (por_rst)
    );

    cu_setup cu_setup_inst (
        .ap_clk          (clk),
        .areset_cu_setup (dut_reset),
        .descriptor_in   (descriptor_in),
        .cu_flush        (cu_flush),
        .response_valid  (response_valid),
        .request_ready   (request_ready),
        .request_out     (request_out),
        .done_out        (done_out)
    );

    // ------------------------------------------------------------
    // Failure reporting and compare tasks
    // ------------------------------------------------------------
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_request(input string test_name, input int index,
                                 input mem_request_payload_t expected,
                                 input mem_request_payload_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR test %0s request %0d: expected %h %s, actual %h %s",
                                test_name, index, expected.address, expected.kind.name(),
                                actual.address, actual.kind.name()));
        end
    endtask

    task automatic check_done(input string test_name, input logic expected,
                              input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR test %0s done_out: expected %b, actual %b",
                                test_name, expected, actual));
        end
    endtask

    // ------------------------------------------------------------
    // Memory model and request monitor sampled on the falling edge
    // ------------------------------------------------------------
    always @(negedge clk) begin : memory_model
        int                   roll;
        int                   rel;
        int                   total;
        mem_request_payload_t exp_req;
        cycle = cycle + 1;
        if (!monitor_on) begin
            release_q.delete();
            prog_seen  = 0;
            flush_seen = 0;
            resp_sent  = 0;
            done_seen  = 1'b0;
            resp_next  = 1'b0;
            ready_next = 1'b1;
        end else begin
            total = int'(cur.program_count) + (cur.flush_enable ? int'(cur.flush_count) : 0);
            resp_next = 1'b0;
            if (release_q.size() > 0 && release_q[0] <= cycle) begin
                resp_next = 1'b1;
                void'(release_q.pop_front());
                resp_sent = resp_sent + 1;
            end
            if (request_out.valid) begin
                // Ready register and output register lie between ready and valid
                if (!ready_d2) begin
                    abort_run($sformatf("Test %0s issued a request without request_ready",
                                        cur_name));
                end
                if (prog_seen < int'(cur.program_count)) begin
                    exp_req.address = cur.program_base + (mem_addr_t'(prog_seen) << BEAT_SHIFT);
                    exp_req.kind    = BUF_SETUP;
                    check_request(cur_name, prog_seen, exp_req, request_out.payload);
                    prog_seen = prog_seen + 1;
                end else if (cur.flush_enable && flush_seen < int'(cur.flush_count)) begin
                    if (!cu_flush || resp_sent < int'(cur.program_count)) begin
                        abort_run($sformatf("Test %0s issued a flush request too early",
                                            cur_name));
                    end
                    exp_req.address = cur.flush_base + (mem_addr_t'(flush_seen) << BEAT_SHIFT);
                    exp_req.kind    = BUF_FLUSH;
                    check_request(cur_name, flush_seen, exp_req, request_out.payload);
                    flush_seen = flush_seen + 1;
                end else begin
                    abort_run($sformatf("Test %0s issued an unexpected request at %h",
                                        cur_name, request_out.payload.address));
                end
                // One in-order response per taken request
                rel = cycle + 1 + int'($unsigned($random(seed)) % 32'd8);
                if (release_q.size() > 0 && rel <= release_q[$]) begin
                    rel = release_q[$] + 1;
                end
                release_q.push_back(rel);
            end
            if (resp_sent < total) begin
                check_done(cur_name, 1'b0, done_out);
            end
            if (done_seen) begin
                check_done(cur_name, 1'b1, done_out);
            end
            if (done_out) begin
                done_seen = 1'b1;
            end
            roll = int'($unsigned($random(seed)) % 32'd100);
            ready_next = (roll >= cur.stall_pct);
        end
        ready_d2 = ready_d1;
        ready_d1 = request_ready;
    end

    always @(posedge clk) begin : drive_memory_side
        request_ready  <= ready_next;
        response_valid <= resp_next;
    end

    // ------------------------------------------------------------
    // Test sequencing
    // ------------------------------------------------------------
    task automatic load_tests();
        int              fd;
        int              n;
        int              pc;
        int              fe;
        int              fc;
        int              st;
        int              dly;
        int              total_beats;
        logic [31:0]     pb;
        logic [31:0]     fb;
        logic [8*24-1:0] name_buf;
        string           line;
        test_vector_t    tv;
        total_beats = 0;
        fd = $fopen("verif/cu_setup_tests.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open verif/cu_setup_tests.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n") begin
                continue;
            end
            n = $sscanf(line, "%s %h %d %d %h %d %d %d",
                        name_buf, pb, pc, fe, fb, fc, st, dly);
            if (n != 8) begin
                abort_run($sformatf("Malformed line in tests file: %0s", line));
            end
            tv.name          = name_buf;
            tv.program_base  = pb;
            tv.program_count = count_t'(pc);
            tv.flush_enable  = (fe != 0);
            tv.flush_base    = fb;
            tv.flush_count   = count_t'(fc);
            tv.stall_pct     = st;
            tv.flush_delay   = dly;
            tests.push_back(tv);
            total_beats = total_beats + pc + fc;
        end
        $fclose(fd);
        if (tests.size() == 0) begin
            abort_run("Tests file holds no tests");
        end
        watchdog_cycles = 200 * tests.size() + 40 * total_beats;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        test_rst      <= 1'b1;
        descriptor_in <= '0;
        cu_flush      <= 1'b0;
        repeat (5) @(posedge clk);
        test_rst <= 1'b0;
    endtask

    task automatic run_test(input test_vector_t tv);
        kernel_descriptor_t d;
        int                 waited;
        int                 exp_flush;
        cur      = tv;
        cur_name = $sformatf("%0s", tv.name);
        apply_reset();
        // Outputs stay quiet until a descriptor arrives
        repeat (3) begin
            @(negedge clk);
            if (request_out.valid !== 1'b0) begin
                abort_run($sformatf("Test %0s saw a request before any descriptor", cur_name));
            end
            check_done(cur_name, 1'b0, done_out);
        end
        d.valid         = 1'b1;
        d.program_base  = tv.program_base;
        d.program_count = tv.program_count;
        d.flush_enable  = tv.flush_enable;
        d.flush_base    = tv.flush_base;
        d.flush_count   = tv.flush_count;
        @(posedge clk);
        monitor_on    = 1'b1;
        descriptor_in <= d;
        waited = 0;
        while (!done_seen) begin
            @(posedge clk);
            if (waited == 0) begin
                descriptor_in.valid <= 1'b0;
            end
            if (waited == tv.flush_delay) begin
                cu_flush <= 1'b1;
            end
            waited = waited + 1;
        end
        // Done must hold with no further requests
        repeat (20) @(posedge clk);
        exp_flush = tv.flush_enable ? int'(tv.flush_count) : 0;
        if (prog_seen != int'(tv.program_count) || flush_seen != exp_flush) begin
            abort_run($sformatf("Test %0s ended with %0d program and %0d flush requests",
                                cur_name, prog_seen, flush_seen));
        end
        monitor_on = 1'b0;
        $display("Test %0s done after %0d cycles", cur_name, waited);
    endtask

    initial begin : main
        descriptor_in <= '0;
        cu_flush      <= 1'b0;
        test_rst      <= 1'b0;
        monitor_on   = 1'b0;
        tests_loaded = 1'b0;
        load_tests();
        tests_loaded = 1'b1;
        wait (!por_rst);
        foreach (tests[i]) begin
            run_test(tests[i]);
        end
        $display("All %0d tests completed", tests.size());
        $display("SIMULATION PASSED");
        $finish;
    end

    initial begin : watchdog
        wait (tests_loaded);
        repeat (watchdog_cycles) @(posedge clk);
        abort_run($sformatf("Timeout after %0d cycles in test %0s, FSM state %s",
                            watchdog_cycles, cur_name,
                            cu_setup_inst.cu_setup_fsm_inst.state.name()));
    end

endmodule : cu_setup_tb

`default_nettype wire

// File: verif/cu_setup_tests.txt
# name program_base program_count flush_enable flush_base flush_count stall_pct flush_delay
# bases are hex byte addresses, all other columns are decimal
prog_flush_basic   00001000  8 1 00002000  6  0  2
prog_only          00004000  5 0 00005000  7  0  3
flush_late         00010000  4 1 00020000  4  0 60
flush_early        00030000 12 1 00038000  9 10  0
backpressure_fill  00100000 40 1 00200000 24 60 10
stall_no_flush     0000a000 30 0 00000000  0 40  0
single_beats       00000008  1 1 00000100  1 20  1
empty_flush        00003000  3 1 00006000  0  0  5
wrap_top           ffffffe0  8 1 fffffff8  3 30  4
burst_heavy_stall  00040000 64 1 00080000 32 80 20

// File: compile.f
logic/mem_pkg.sv
logic/cu_setup_pkg.sv
logic/request_fifo.sv
logic/serial_read_engine.sv
logic/cu_setup_fsm.sv
logic/cu_setup.sv
verif/tb_clock_gen.sv
verif/cu_setup_tb.sv

// File: Makefile
TOP := cu_setup_tb
LOG := sim.log

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

obj_dir/V$(TOP): compile.f $(wildcard logic/*.sv) $(wildcard verif/*.sv)
	verilator --binary --timing --assert --timescale 1ns/10ps \
		-f compile.f --top-module $(TOP) -o V$(TOP)

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/10ps \
		-f compile.f --top-module cu_setup

clean:
	rm -rf obj_dir $(LOG)
